//--- files.f
periph_pkg.sv
wb_periph_decoder.sv
interrupt_controller.sv
timer_bank.sv
periph_top.sv
tb_periph_top.sv

//--- Makefile
# Verilator build and run for the peripheral block testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_top
FLIST     ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_STR  ?= Simulation finished: PASS

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuild only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only if the pass line shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_periph_top.sv
/*
 * Testbench for the peripheral block: drives Wishbone accesses into periph_top
 * and checks reads and interrupt outputs against a shadow-register model.
 */
`timescale 1ns/100ps

module tb_periph_top import periph_pkg::*; ();

	localparam int N_TIMERS       = 3;
	localparam int TIMEOUT_CYCLES = 20000;

	logic                 i_clk;
	logic                 i_rstn;
	logic [WB_AW-1:0]     i_wb_adr;
	logic [WB_DW-1:0]     i_wb_dat;
	logic [WB_DW/8-1:0]   i_wb_sel;
	logic                 i_wb_we;
	logic                 i_wb_cyc;
	logic                 i_wb_stb;
	logic [WB_DW-1:0]     o_wb_dat;
	logic                 o_wb_ack;
	logic                 o_wb_err;
	logic [15-N_TIMERS:0] i_ext_irq;
	logic                 o_irq;
	logic                 o_firq;

	// Shadow enables in the order irq0, firq0, irq1, firq1
	logic [31:0]          en_sh [4];
	logic [15:0]          soft_sh;
	logic [15-N_TIMERS:0] pins_sh;
	logic [N_TIMERS-1:0]  flags_sh;
	logic [31:0]          lfsr_state;
	int                   cycle_cnt;

	periph_top #(
		.N_TIMERS (N_TIMERS)
	) i_dut (
		.i_clk     (i_clk),
		.i_rstn    (i_rstn),
		.i_wb_adr  (i_wb_adr),
		.i_wb_dat  (i_wb_dat),
		.i_wb_sel  (i_wb_sel),
		.i_wb_we   (i_wb_we),
		.i_wb_cyc  (i_wb_cyc),
		.i_wb_stb  (i_wb_stb),
		.o_wb_dat  (o_wb_dat),
		.o_wb_ack  (o_wb_ack),
		.o_wb_err  (o_wb_err),
		.i_ext_irq (i_ext_irq),
		.o_irq     (o_irq),
		.o_firq    (o_firq)
	);

	// 4 ns clock
	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	// ====================
	// Reporting
	// ====================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0d ns: %s, got %h expected %h",
				$time, msg, got, exp));
	endtask

	// Run length guard
	always @(posedge i_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			abort_run("timeout: the test sequence did not finish within the cycle limit");
	end

	// ====================
	// Stimulus helpers
	// ====================

	// Galois LFSR with taps 32 31 29 1 and one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        lsb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lsb        = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb)
				lfsr_state = lfsr_state ^ 32'hD000_0001;
			r = {r[30:0], lsb};
		end
		return r;
	endfunction

	function automatic logic [31:0] ic_adr(input logic [9:0] idx);
		return {20'h0_0000, idx, 2'b00};
	endfunction

	// Region 1 with the timer number in bits 11:4
	function automatic logic [31:0] tmr_adr(input logic [7:0] t, input logic [1:0] off);
		return {16'h0000, 4'h1, t, off, 2'b00};
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge i_clk);
	endtask

	// One classic cycle sampled on falling edges with STB dropped after ack or err
	task automatic bus_cycle(input logic [31:0] adr, input logic we, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic ack, output logic err);
		int waited;
		waited = 0;
		@(negedge i_clk);
		i_wb_adr = adr;
		i_wb_dat = wdata;
		i_wb_we  = we;
		i_wb_sel = 4'hF;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		do begin
			@(negedge i_clk);
			waited++;
			if (!(o_wb_ack || o_wb_err) && waited >= 8)
				abort_run($sformatf("bus access to %h got neither ack nor err in 8 cycles", adr));
		end while (!(o_wb_ack || o_wb_err));
		rdata    = o_wb_dat;
		ack      = o_wb_ack;
		err      = o_wb_err;
		i_wb_stb = 1'b0;
		i_wb_cyc = 1'b0;
		i_wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [31:0] adr, input logic [31:0] data, output logic err);
		logic [31:0] unused_dat;
		logic        ack;
		bus_cycle(adr, 1'b1, data, unused_dat, ack, err);
	endtask

	task automatic wb_read(input logic [31:0] adr, output logic [31:0] data, output logic err);
		logic ack;
		bus_cycle(adr, 1'b0, 32'h0, data, ack, err);
	endtask

	// ====================
	// Reference model
	// ====================

	// Expected read word for a controller index, plus expected o_irq and o_firq
	function automatic logic [31:0] model_ic(input logic [9:0] idx,
		output logic exp_irq, output logic exp_firq);
		logic [31:0] raw;
		logic [31:0] word;
		raw      = {pins_sh, flags_sh, soft_sh};
		exp_irq  = (|(raw & en_sh[0])) || (|(raw & en_sh[2]));
		exp_firq = (|(raw & en_sh[1])) || (|(raw & en_sh[3]));
		case (idx)
			IC_IRQ0_ENSET, IC_IRQ0_ENCLR:   word = en_sh[0];
			IC_FIRQ0_ENSET, IC_FIRQ0_ENCLR: word = en_sh[1];
			IC_IRQ1_ENSET, IC_IRQ1_ENCLR:   word = en_sh[2];
			IC_FIRQ1_ENSET, IC_FIRQ1_ENCLR: word = en_sh[3];
			IC_IRQ0_RAW, IC_FIRQ0_RAW,
			IC_IRQ1_RAW, IC_FIRQ1_RAW:      word = raw;
			IC_IRQ0_STAT:                   word = raw & en_sh[0];
			IC_FIRQ0_STAT:                  word = raw & en_sh[1];
			IC_IRQ1_STAT:                   word = raw & en_sh[2];
			IC_FIRQ1_STAT:                  word = raw & en_sh[3];
			IC_SOFT_SET, IC_SOFT_CLR:       word = {16'h0000, soft_sh};
			default:                        word = IC_READ_FILL;
		endcase
		return word;
	endfunction

	// ====================
	// Checking tasks
	// ====================
	task automatic ic_write(input logic [9:0] idx, input logic [31:0] data);
		logic err;
		wb_write(ic_adr(idx), data, err);
		check_equal({31'd0, err}, 32'd0, $sformatf("err on controller write %0d", idx));
	endtask

	task automatic ic_check(input logic [9:0] idx, input string msg);
		logic [31:0] exp;
		logic [31:0] got;
		logic        ei;
		logic        ef;
		logic        err;
		exp = model_ic(idx, ei, ef);
		wb_read(ic_adr(idx), got, err);
		check_equal({31'd0, err}, 32'd0, $sformatf("%s, err on index %0d", msg, idx));
		check_equal(got, exp, $sformatf("%s, index %0d", msg, idx));
	endtask

	task automatic irq_check(input string msg);
		logic [31:0] unused_word;
		logic        ei;
		logic        ef;
		unused_word = model_ic(IC_IRQ0_ENSET, ei, ef);
		check_equal({31'd0, o_irq}, {31'd0, ei}, {msg, ", o_irq"});
		check_equal({31'd0, o_firq}, {31'd0, ef}, {msg, ", o_firq"});
	endtask

	task automatic set_enable(input int r, input logic setting, input logic [31:0] data);
		logic [9:0] idx;
		idx = 10'(r * 4) + (setting ? 10'd0 : 10'd1);
		if (setting)
			en_sh[r] = en_sh[r] | data;
		else
			en_sh[r] = en_sh[r] & ~data;
		ic_write(idx, data);
	endtask

	// After a soft write the outputs hold for two falling edges and move on the third
	task automatic soft_step(input logic [9:0] idx, input logic [31:0] data, input string msg);
		logic [31:0] unused_word;
		logic        old_irq;
		logic        old_firq;
		logic        new_irq;
		logic        new_firq;
		unused_word = model_ic(idx, old_irq, old_firq);
		if (idx == IC_SOFT_SET)
			soft_sh = soft_sh | data[15:0];
		else
			soft_sh = soft_sh & ~data[15:0];
		unused_word = model_ic(idx, new_irq, new_firq);
		ic_write(idx, data);
		check_equal({30'd0, o_irq, o_firq}, {30'd0, old_irq, old_firq}, {msg, ", edge 1"});
		@(negedge i_clk);
		check_equal({30'd0, o_irq, o_firq}, {30'd0, old_irq, old_firq}, {msg, ", edge 2"});
		@(negedge i_clk);
		check_equal({30'd0, o_irq, o_firq}, {30'd0, new_irq, new_firq}, {msg, ", edge 3"});
		ic_check(idx, {msg, ", soft register"});
		ic_check(IC_IRQ0_RAW, {msg, ", raw status"});
	endtask

	task automatic tmr_write(input logic [7:0] t, input logic [1:0] off, input logic [31:0] data);
		logic err;
		wb_write(tmr_adr(t, off), data, err);
		check_equal({31'd0, err}, 32'd0, $sformatf("err on timer %0d write", t));
	endtask

	task automatic tmr_check(input logic [7:0] t, input logic [1:0] off,
		input logic [31:0] exp, input string msg);
		logic [31:0] got;
		logic        err;
		wb_read(tmr_adr(t, off), got, err);
		check_equal({31'd0, err}, 32'd0, $sformatf("%s, err on timer %0d", msg, t));
		check_equal(got, exp, $sformatf("%s, timer %0d offset %0d", msg, t, off));
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		logic [31:0] rnd;
		logic [31:0] data;
		logic [31:0] got;
		logic [15:0] load_val;
		logic        setting;
		logic        ack;
		logic        err;
		int          r;

		i_rstn     = 1'b0;
		i_wb_adr   = '0;
		i_wb_dat   = '0;
		i_wb_sel   = '0;
		i_wb_we    = 1'b0;
		i_wb_cyc   = 1'b0;
		i_wb_stb   = 1'b0;
		i_ext_irq  = '0;
		lfsr_state = 32'h45ad_6630;
		cycle_cnt  = 0;
		soft_sh    = '0;
		pins_sh    = '0;
		flags_sh   = '0;
		for (int k = 0; k < 4; k++)
			en_sh[k] = '0;
		repeat (4) @(negedge i_clk);
		i_rstn = 1'b1;

		// Reset values, then random set and clear writes
		for (int k = 0; k < 18; k++)
			ic_check(10'(k), "reset value");
		for (int k = 0; k < 16; k++) begin
			rnd     = rand_bits(2);
			r       = int'(rnd[1:0]);
			rnd     = rand_bits(1);
			setting = rnd[0];
			data    = rand_bits(32);
			set_enable(r, setting, data);
			ic_check(10'(r * 4), "enable read-back");
		end

		// Pin levels against raw and masked status
		for (int k = 0; k < 6; k++) begin
			rnd     = rand_bits(16 - N_TIMERS);
			pins_sh = rnd[15-N_TIMERS:0];
			@(negedge i_clk);
			i_ext_irq = pins_sh;
			for (int e = 0; e < 4; e++) begin
				set_enable(e, 1'b0, 32'hFFFF_FFFF);
				data = rand_bits(32);
				set_enable(e, 1'b1, data);
			end
			wait_cycles(4);
			for (int i = 0; i < 16; i++)
				ic_check(10'(i), "status with random pins");
			irq_check("outputs with random pins");
		end

		// Soft interrupts with irq0 and firq1 watching the low half
		pins_sh = '0;
		@(negedge i_clk);
		i_ext_irq = pins_sh;
		for (int e = 0; e < 4; e++)
			set_enable(e, 1'b0, 32'hFFFF_FFFF);
		set_enable(0, 1'b1, 32'h0000_FFFF);
		data = rand_bits(16);
		set_enable(3, 1'b1, data);
		wait_cycles(4);
		irq_check("soft idle");
		data = rand_bits(32);
		soft_step(IC_SOFT_SET, data | 32'h1, "soft set");
		data = rand_bits(32);
		soft_step(IC_SOFT_CLR, data, "soft partial clear");
		data = rand_bits(32);
		soft_step(IC_SOFT_SET, data, "soft set again");
		soft_step(IC_SOFT_CLR, 32'hFFFF_FFFF, "soft clear all");
		irq_check("soft dropped");

		// One-shot timer 0
		rnd      = rand_bits(2);
		load_val = 16'd3 + {14'd0, rnd[1:0]};
		tmr_write(8'd0, TMR_LOAD, {16'h0000, load_val});
		tmr_write(8'd0, TMR_CTRL, 32'h1);
		wait_cycles(int'(load_val) + 6);
		flags_sh[0] = 1'b1;
		tmr_check(8'd0, TMR_CLEAR, 32'h1, "one-shot flag");
		tmr_check(8'd0, TMR_VALUE, 32'h0, "one-shot stopped");
		tmr_check(8'd0, TMR_CTRL, 32'h0, "one-shot enable cleared");
		ic_check(IC_IRQ0_RAW, "one-shot raw bit");
		irq_check("one-shot outputs");
		tmr_write(8'd0, TMR_CLEAR, 32'h0);
		flags_sh[0] = 1'b0;
		tmr_check(8'd0, TMR_CLEAR, 32'h0, "one-shot flag cleared");
		wait_cycles(4);
		ic_check(IC_IRQ0_RAW, "one-shot raw cleared");
		irq_check("one-shot outputs cleared");

		// Periodic timer 1 with a load long enough that the clear and its read fall
		// between two expiries, so the second flag comes from the reload alone
		rnd      = rand_bits(3);
		load_val = 16'd24 + {13'd0, rnd[2:0]};
		tmr_write(8'd1, TMR_LOAD, {16'h0000, load_val});
		tmr_write(8'd1, TMR_CTRL, 32'h3);
		wait_cycles(int'(load_val) + 6);
		flags_sh[1] = 1'b1;
		tmr_check(8'd1, TMR_CLEAR, 32'h1, "periodic first flag");
		tmr_check(8'd1, TMR_CTRL, 32'h3, "periodic still enabled");
		ic_check(IC_IRQ0_RAW, "periodic raw bit");
		tmr_write(8'd1, TMR_CLEAR, 32'h0);
		flags_sh[1] = 1'b0;
		tmr_check(8'd1, TMR_CLEAR, 32'h0, "periodic flag cleared");
		wait_cycles(int'(load_val) + 6);
		flags_sh[1] = 1'b1;
		tmr_check(8'd1, TMR_CLEAR, 32'h1, "periodic flag set again");
		tmr_write(8'd1, TMR_CTRL, 32'h0);
		tmr_write(8'd1, TMR_CLEAR, 32'h0);
		flags_sh[1] = 1'b0;
		tmr_check(8'd1, TMR_CLEAR, 32'h0, "periodic stopped and cleared");
		wait_cycles(4);
		irq_check("timers idle");

		// Undefined indices, missing timer, unmapped regions
		ic_check(10'd18, "undefined index");
		ic_check(10'd31, "undefined index");
		ic_check(10'd1023, "undefined index");
		tmr_check(8'(N_TIMERS), TMR_VALUE, 32'h0, "timer beyond bank");
		bus_cycle(32'h0000_5000, 1'b0, 32'h0, got, ack, err);
		check_equal({30'd0, err, ack}, 32'h2, "unmapped read err and ack");
		bus_cycle(32'h0000_F004, 1'b1, 32'hDEAD_BEEF, got, ack, err);
		check_equal({30'd0, err, ack}, 32'h2, "unmapped write err and ack");
		irq_check("final outputs");

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- periph_top.sv
/*
 * Peripheral block top: decoder, interrupt controller and timer bank
 * on one Wishbone classic slave port.
 */
`timescale 1ns/100ps

module periph_top import periph_pkg::*; #(
	parameter int N_TIMERS = 3
) (
	input  logic                 i_clk,
	input  logic                 i_rstn,
	// Wishbone classic slave
	input  logic [WB_AW-1:0]     i_wb_adr,
	input  logic [WB_DW-1:0]     i_wb_dat,
	input  logic [WB_DW/8-1:0]   i_wb_sel,
	input  logic                 i_wb_we,
	input  logic                 i_wb_cyc,
	input  logic                 i_wb_stb,
	output logic [WB_DW-1:0]     o_wb_dat,
	output logic                 o_wb_ack,
	output logic                 o_wb_err,
	// Interrupt pins and outputs
	input  logic [15-N_TIMERS:0] i_ext_irq,
	output logic                 o_irq,
	output logic                 o_firq
);

	logic                 bus_stb;
	logic                 ic_stb;
	logic                 tmr_stb;
	logic [WB_DW-1:0]     ic_dat;
	logic                 ic_ack;
	logic [WB_DW-1:0]     tmr_dat;
	logic                 tmr_ack;
	logic [N_TIMERS-1:0]  tmr_irq;
	logic [N_SRC/2-1:0]   hw_src;

	// Strobe only counts inside a cycle, byte selects have no effect
	assign bus_stb = i_wb_stb && i_wb_cyc;

	// Pins above, timer flags in the low bits
	assign hw_src = {i_ext_irq, tmr_irq};

	wb_periph_decoder u_dec (
		.i_wb_adr  (i_wb_adr),
		.i_wb_stb  (bus_stb),
		.i_wb_we   (i_wb_we),
		.o_wb_dat  (o_wb_dat),
		.o_wb_ack  (o_wb_ack),
		.o_wb_err  (o_wb_err),
		.o_ic_stb  (ic_stb),
		.o_tmr_stb (tmr_stb),
		.i_ic_dat  (ic_dat),
		.i_ic_ack  (ic_ack),
		.i_tmr_dat (tmr_dat),
		.i_tmr_ack (tmr_ack)
	);

	interrupt_controller u_ic (
		.i_clk        (i_clk),
		.i_rstn       (i_rstn),
		.i_wb_adr     (i_wb_adr),
		.i_wb_dat     (i_wb_dat),
		.i_wb_we      (i_wb_we),
		.i_wb_stb     (ic_stb),
		.o_wb_dat     (ic_dat),
		.o_wb_ack     (ic_ack),
		.i_interrupts (hw_src),
		.o_irq        (o_irq),
		.o_firq       (o_firq)
	);

	timer_bank #(
		.N_TIMERS (N_TIMERS)
	) u_tmr (
		.i_clk     (i_clk),
		.i_rstn    (i_rstn),
		.i_wb_adr  (i_wb_adr),
		.i_wb_dat  (i_wb_dat),
		.i_wb_we   (i_wb_we),
		.i_wb_stb  (tmr_stb),
		.o_wb_dat  (tmr_dat),
		.o_wb_ack  (tmr_ack),
		.o_tmr_irq (tmr_irq)
	);

endmodule

//--- timer_bank.sv
/*
 * Bank of 16-bit down-counting timers behind a Wishbone slave port.
 * Each timer raises a sticky interrupt flag when it reaches zero.
 */
`timescale 1ns/100ps

module timer_bank import periph_pkg::*; #(
	parameter int N_TIMERS = 3
) (
	input  logic                i_clk,
	input  logic                i_rstn,
	input  logic [WB_AW-1:0]    i_wb_adr,
	input  logic [WB_DW-1:0]    i_wb_dat,
	input  logic                i_wb_we,
	input  logic                i_wb_stb,
	output logic [WB_DW-1:0]    o_wb_dat,
	output logic                o_wb_ack,
	output logic [N_TIMERS-1:0] o_tmr_irq
);

	logic                start_write;
	logic                start_read;
	logic                rd_valid_q;
	logic [WB_DW-1:0]    rdata_q;
	tmr_reg_e            reg_off;
	logic [N_TIMERS-1:0] tmr_sel;
	logic [WB_DW-1:0]    tmr_word [N_TIMERS];
	logic [WB_DW-1:0]    rd_mux;

	// ====================
	// Bus handshake
	// ====================
	assign reg_off     = tmr_reg_e'(i_wb_adr[3:2]);
	assign start_write = i_wb_stb && i_wb_we && !rd_valid_q;
	assign start_read  = i_wb_stb && !i_wb_we && !rd_valid_q;

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= i_wb_stb && !i_wb_we;
		end
	end

	assign o_wb_ack = i_wb_stb && (start_write || rd_valid_q);
	assign o_wb_dat = rdata_q;

	// ====================
	// Timers
	// ====================
	for (genvar t = 0; t < N_TIMERS; t++) begin : g_tmr
		logic [15:0] load_q;
		logic [15:0] cnt_q;
		logic        en_q;
		logic        per_q;
		logic        flag_q;
		logic        wr;
		logic        expire;

		// Timer t owns words t*4 to t*4+3
		assign tmr_sel[t] = (i_wb_adr[11:4] == 8'(t));
		assign wr         = start_write && tmr_sel[t];
		assign expire     = en_q && (cnt_q == 16'd1);

		// Reload value for the counter
		always_ff @(posedge i_clk) begin
			if (wr && reg_off == TMR_LOAD)
				load_q <= i_wb_dat[15:0];
		end

		always_ff @(posedge i_clk) begin
			if (!i_rstn) begin
				cnt_q  <= '0;
				en_q   <= 1'b0;
				per_q  <= 1'b0;
				flag_q <= 1'b0;
			end else begin
				// Count down, reload or stop on expiry
				if (expire) begin
					cnt_q <= per_q ? load_q : 16'd0;
					en_q  <= per_q;
				end else if (en_q && cnt_q != 16'd0) begin
					cnt_q <= cnt_q - 16'd1;
				end
				// CTRL write restarts the counter from LOAD
				if (wr && reg_off == TMR_CTRL) begin
					en_q  <= i_wb_dat[0];
					per_q <= i_wb_dat[1];
					if (i_wb_dat[0])
						cnt_q <= load_q;
				end
				// Expiry wins over a clear on the same edge
				flag_q <= (flag_q && !(wr && reg_off == TMR_CLEAR)) || expire;
			end
		end

		always_comb begin
			case (reg_off)
				TMR_LOAD:  tmr_word[t] = {16'd0, load_q};
				TMR_VALUE: tmr_word[t] = {16'd0, cnt_q};
				TMR_CTRL:  tmr_word[t] = {30'd0, per_q, en_q};
				default:   tmr_word[t] = {31'd0, flag_q};
			endcase
		end

		assign o_tmr_irq[t] = flag_q;
	end

	// Unselected or missing timers read 0
	always_comb begin
		rd_mux = '0;
		for (int t = 0; t < N_TIMERS; t++) begin
			if (tmr_sel[t])
				rd_mux = tmr_word[t];
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstn)
			rdata_q <= '0;
		else if (start_read)
			rdata_q <= rd_mux;
	end

endmodule

//--- interrupt_controller.sv
/*
 * Wishbone slave interrupt controller: enable set/clear, soft interrupts,
 * raw and masked status, registered o_irq and o_firq outputs.
 */
`timescale 1ns/100ps

module interrupt_controller import periph_pkg::*; (
	input  logic                 i_clk,
	input  logic                 i_rstn,
	input  logic [WB_AW-1:0]     i_wb_adr,
	input  logic [WB_DW-1:0]     i_wb_dat,
	input  logic                 i_wb_we,
	input  logic                 i_wb_stb,
	output logic [WB_DW-1:0]     o_wb_dat,
	output logic                 o_wb_ack,
	input  logic [N_SRC/2-1:0]   i_interrupts,
	output logic                 o_irq,
	output logic                 o_firq
);

	// Enable and soft registers
	logic [N_SRC-1:0]   irq0_en_q;
	logic [N_SRC-1:0]   firq0_en_q;
	logic [N_SRC-1:0]   irq1_en_q;
	logic [N_SRC-1:0]   firq1_en_q;
	logic [N_SRC/2-1:0] soft_q;

	// Raw and masked source vectors
	logic [N_SRC-1:0]   raw_src;
	logic [N_SRC-1:0]   irq0_q;
	logic [N_SRC-1:0]   firq0_q;
	logic [N_SRC-1:0]   irq1_q;
	logic [N_SRC-1:0]   firq1_q;

	// Bus handshake
	logic               start_write;
	logic               start_read;
	logic               rd_valid_q;
	logic [WB_DW-1:0]   rdata_q;
	ic_reg_e            reg_idx;

	// ====================
	// Bus handshake
	// ====================

	// Word index within the region
	assign reg_idx = ic_reg_e'(i_wb_adr[11:2]);

	// No write while a read is still waiting for its ack
	assign start_write = i_wb_stb && i_wb_we && !rd_valid_q;
	assign start_read  = i_wb_stb && !i_wb_we && !rd_valid_q;

	// Read ack one cycle after STB, held until STB drops
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= i_wb_stb && !i_wb_we;
		end
	end

	// Write ack is combinational
	assign o_wb_ack = i_wb_stb && (start_write || rd_valid_q);
	assign o_wb_dat = rdata_q;

	// ====================
	// Interrupt masking
	// ====================

	// Pins and timers on top, soft bits below
	assign raw_src = {i_interrupts, soft_q};

	// Masked vectors take one edge, outputs another
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			irq0_q  <= '0;
			firq0_q <= '0;
			irq1_q  <= '0;
			firq1_q <= '0;
			o_irq   <= 1'b0;
			o_firq  <= 1'b0;
		end else begin
			irq0_q  <= raw_src & irq0_en_q;
			firq0_q <= raw_src & firq0_en_q;
			irq1_q  <= raw_src & irq1_en_q;
			firq1_q <= raw_src & firq1_en_q;
			o_irq   <= (|irq0_q) | (|irq1_q);
			o_firq  <= (|firq0_q) | (|firq1_q);
		end
	end

	// ====================
	// Register writes
	// ====================

	// Set index ORs data in, clear index removes it
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			irq0_en_q  <= '0;
			firq0_en_q <= '0;
			irq1_en_q  <= '0;
			firq1_en_q <= '0;
			soft_q     <= '0;
		end else if (start_write) begin
			case (reg_idx)
				IC_IRQ0_ENSET:  irq0_en_q  <= irq0_en_q | i_wb_dat;
				IC_IRQ0_ENCLR:  irq0_en_q  <= irq0_en_q & ~i_wb_dat;
				IC_FIRQ0_ENSET: firq0_en_q <= firq0_en_q | i_wb_dat;
				IC_FIRQ0_ENCLR: firq0_en_q <= firq0_en_q & ~i_wb_dat;
				IC_IRQ1_ENSET:  irq1_en_q  <= irq1_en_q | i_wb_dat;
				IC_IRQ1_ENCLR:  irq1_en_q  <= irq1_en_q & ~i_wb_dat;
				IC_FIRQ1_ENSET: firq1_en_q <= firq1_en_q | i_wb_dat;
				IC_FIRQ1_ENCLR: firq1_en_q <= firq1_en_q & ~i_wb_dat;
				IC_SOFT_SET:    soft_q     <= soft_q | i_wb_dat[N_SRC/2-1:0];
				IC_SOFT_CLR:    soft_q     <= soft_q & ~i_wb_dat[N_SRC/2-1:0];
				default: ;
			endcase
		end
	end

	// ====================
	// Register reads
	// ====================

	// Data captured on the first edge of the read
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			rdata_q <= '0;
		end else if (start_read) begin
			case (reg_idx)
				IC_IRQ0_ENSET,
				IC_IRQ0_ENCLR:  rdata_q <= irq0_en_q;
				IC_FIRQ0_ENSET,
				IC_FIRQ0_ENCLR: rdata_q <= firq0_en_q;
				IC_IRQ1_ENSET,
				IC_IRQ1_ENCLR:  rdata_q <= irq1_en_q;
				IC_FIRQ1_ENSET,
				IC_FIRQ1_ENCLR: rdata_q <= firq1_en_q;
				IC_IRQ0_RAW,
				IC_FIRQ0_RAW,
				IC_IRQ1_RAW,
				IC_FIRQ1_RAW:   rdata_q <= raw_src;
				IC_IRQ0_STAT:   rdata_q <= irq0_q;
				IC_FIRQ0_STAT:  rdata_q <= firq0_q;
				IC_IRQ1_STAT:   rdata_q <= irq1_q;
				IC_FIRQ1_STAT:  rdata_q <= firq1_q;
				// Soft bits zero-padded to the bus width
				IC_SOFT_SET,
				IC_SOFT_CLR:    rdata_q <= {{(WB_DW-N_SRC/2){1'b0}}, soft_q};
				default:        rdata_q <= IC_READ_FILL;
			endcase
		end
	end

endmodule

//--- wb_periph_decoder.sv
/*
 * Wishbone address decoder: steers the strobe by region, muxes the selected
 * slave's read data and ack, and flags unmapped regions with err.
 */
`timescale 1ns/100ps

module wb_periph_decoder import periph_pkg::*; (
	// Master side
	input  logic [WB_AW-1:0] i_wb_adr,
	input  logic             i_wb_stb,
	input  logic             i_wb_we,
	output logic [WB_DW-1:0] o_wb_dat,
	output logic             o_wb_ack,
	output logic             o_wb_err,
	// Slave strobes
	output logic             o_ic_stb,
	output logic             o_tmr_stb,
	// Slave returns
	input  logic [WB_DW-1:0] i_ic_dat,
	input  logic             i_ic_ack,
	input  logic [WB_DW-1:0] i_tmr_dat,
	input  logic             i_tmr_ack
);

	region_e          region;
	logic             mapped;
	logic [WB_DW-1:0] sel_dat;

	// Region code from bits 15:12
	assign region = region_e'(i_wb_adr[15:12]);

	// ====================
	// Strobe steering
	// ====================
	assign o_ic_stb  = i_wb_stb && (region == REGION_IC);
	assign o_tmr_stb = i_wb_stb && (region == REGION_TMR);

	// ====================
	// Return path
	// ====================
	always_comb begin
		case (region)
			REGION_IC: begin
				sel_dat  = i_ic_dat;
				o_wb_ack = i_ic_ack;
				mapped   = 1'b1;
			end
			REGION_TMR: begin
				sel_dat  = i_tmr_dat;
				o_wb_ack = i_tmr_ack;
				mapped   = 1'b1;
			end
			default: begin
				// Unmapped, no ack and no data
				sel_dat  = '0;
				o_wb_ack = 1'b0;
				mapped   = 1'b0;
			end
		endcase
	end

	// Read data only on reads
	assign o_wb_dat = i_wb_we ? '0 : sel_dat;

	// Err in the same cycle as STB
	assign o_wb_err = i_wb_stb && !mapped;

endmodule

//--- periph_pkg.sv
/*
 * Shared register maps, region codes and bus widths for the peripheral block.
 * Imported by the RTL modules and the testbench.
 */
package periph_pkg;

	// Bus widths
	localparam int WB_DW = 32;
	localparam int WB_AW = 32;

	// Interrupt sources, low half soft and high half hardware
	localparam int N_SRC = 32;

	// Word returned for an undefined controller index
	localparam logic [WB_DW-1:0] IC_READ_FILL = 32'h2233_4455;

	// Interrupt controller word indices, taken from address bits 11:2
	typedef enum logic [9:0] {
		IC_IRQ0_ENSET  = 10'd0,
		IC_IRQ0_ENCLR  = 10'd1,
		IC_IRQ0_RAW    = 10'd2,
		IC_IRQ0_STAT   = 10'd3,
		IC_FIRQ0_ENSET = 10'd4,
		IC_FIRQ0_ENCLR = 10'd5,
		IC_FIRQ0_RAW   = 10'd6,
		IC_FIRQ0_STAT  = 10'd7,
		IC_IRQ1_ENSET  = 10'd8,
		IC_IRQ1_ENCLR  = 10'd9,
		IC_IRQ1_RAW    = 10'd10,
		IC_IRQ1_STAT   = 10'd11,
		IC_FIRQ1_ENSET = 10'd12,
		IC_FIRQ1_ENCLR = 10'd13,
		IC_FIRQ1_RAW   = 10'd14,
		IC_FIRQ1_STAT  = 10'd15,
		IC_SOFT_SET    = 10'd16,
		IC_SOFT_CLR    = 10'd17
	} ic_reg_e;

	// Per-timer register offsets, timer t at word t*4 + offset
	typedef enum logic [1:0] {
		TMR_LOAD  = 2'd0,
		TMR_VALUE = 2'd1,
		TMR_CTRL  = 2'd2,
		TMR_CLEAR = 2'd3
	} tmr_reg_e;

	// Address regions from bits 15:12, all other codes unmapped
	typedef enum logic [3:0] {
		REGION_IC  = 4'h0,
		REGION_TMR = 4'h1
	} region_e;

endpackage
